// ==== include/wbh_params.svh ====
// bridge widths, local-select bit, bank reset value and register indices
`ifndef WBH_PARAMS_SVH
`define WBH_PARAMS_SVH

`define WBH_DW        32       // data bus width
`define WBH_AW        32       // address bus width
`define WBH_SEL_W     4        // one select per byte
`define WBH_BANK_W    8        // bank select width
`define WBH_OFFS_W    24       // address bits passed below the bank
`define WBH_LOCAL_BIT 23       // set -> local register space
`define WBH_BANK_RST  8'h10    // bank select after reset

// register index from adr[3:2]
`define WBH_REG_AW    2
`define WBH_REG_LSB   2
`define WBH_IDX_GLB   2'd0     // global control
`define WBH_IDX_BANK  2'd1     // bank select
`define WBH_IDX_CLK1  2'd2     // clock control 1
`define WBH_IDX_CLK2  2'd3     // clock control 2
`endif

// ==== hdl/wbh_pkg.sv ====
// bridge data, address, select and bank types, response struct, register index enum
`include "wbh_params.svh"

package wbh_pkg;

   typedef logic [`WBH_DW-1:0]     wbh_data_t;   // data word
   typedef logic [`WBH_AW-1:0]     wbh_addr_t;   // byte address
   typedef logic [`WBH_SEL_W-1:0]  wbh_sel_t;    // byte enables
   typedef logic [`WBH_BANK_W-1:0] wbh_bank_t;   // upper address bank

   // target response per transaction
   typedef struct packed {
      logic      ack;     // one-cycle done
      logic      err;     // one-cycle error
      wbh_data_t rdata;   // read data, valid with ack
   } wbh_rsp_t;

   typedef enum logic [`WBH_REG_AW-1:0] {
      REG_GLB  = `WBH_IDX_GLB,
      REG_BANK = `WBH_IDX_BANK,
      REG_CLK1 = `WBH_IDX_CLK1,
      REG_CLK2 = `WBH_IDX_CLK2
   } wbh_reg_e;

endpackage

// ==== hdl/wbh_req_if.sv ====
// request interface from the front stage to one target with front and target modports
`timescale 1ns/1ns
interface wbh_req_if
   import wbh_pkg::*;
();

   logic      req;     // held until front sees ack/err
   wbh_addr_t adr;     // full master address
   logic      we;      // 1 = write
   wbh_data_t wdata;   // write data
   wbh_sel_t  sel;     // byte enables

   // front stage side
   modport front (
      output req,
      output adr,
      output we,
      output wdata,
      output sel
   );

   // register file or external port side
   modport target (
      input  req,
      input  adr,
      input  we,
      input  wdata,
      input  sel
   );

endinterface

// ==== hdl/wbh_front.sv ====
// front stage with request qualification, local/external steering and registered response
`timescale 1ns/1ns
`include "wbh_params.svh"

module wbh_front
   import wbh_pkg::*;
(
   input  logic       wbm_clk_i,
   input  logic       wbm_rst_n,
   input  logic       wbm_cyc_i,   // master cycle
   input  logic       wbm_stb_i,   // master strobe
   input  logic       wbm_we_i,
   input  wbh_addr_t  wbm_adr_i,
   input  wbh_data_t  wbm_dat_i,
   input  wbh_sel_t   wbm_sel_i,
   wbh_req_if.front   reg_req,     // to local registers
   wbh_req_if.front   ext_req,     // to external port
   input  wbh_rsp_t   reg_rsp_i,
   input  wbh_rsp_t   ext_rsp_i,
   output wbh_data_t  wbm_dat_o,   // holds last read data
   output logic       wbm_ack_o,
   output logic       wbm_err_o
);

   logic      req_q;     // qualified request, registered
   logic      local_q;   // address bit 23 of held request
   wbh_addr_t adr_q;
   logic      we_q;
   wbh_data_t wdata_q;
   wbh_sel_t  sel_q;
   wbh_rsp_t  rsp_sel;   // response of the addressed target
   logic      rsp_busy;  // response in flight or being returned

   // ------------------------------
   // request path
   // ------------------------------
   assign rsp_sel  = local_q ? reg_rsp_i : ext_rsp_i;
   assign rsp_busy = rsp_sel.ack | rsp_sel.err | wbm_ack_o | wbm_err_o;

   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
         req_q <= 1'b0;
      else
         req_q <= wbm_cyc_i & wbm_stb_i & ~rsp_busy;   // drop once target answers
   end

   // fields load only between transactions and hold while req is high
   always_ff @(posedge wbm_clk_i)
   begin
      if (!req_q)
      begin
         local_q <= wbm_adr_i[`WBH_LOCAL_BIT];   // the one local/external decision
         adr_q   <= wbm_adr_i;
         we_q    <= wbm_we_i;
         wdata_q <= wbm_dat_i;
         sel_q   <= wbm_sel_i;
      end
   end

   // steer to one target
   assign reg_req.req   = req_q & local_q;
   assign reg_req.adr   = adr_q;
   assign reg_req.we    = we_q;
   assign reg_req.wdata = wdata_q;
   assign reg_req.sel   = sel_q;

   assign ext_req.req   = req_q & ~local_q;
   assign ext_req.adr   = adr_q;
   assign ext_req.we    = we_q;
   assign ext_req.wdata = wdata_q;
   assign ext_req.sel   = sel_q;

   // ------------------------------
   // response path
   // ------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbm_ack_o <= 1'b0;
         wbm_err_o <= 1'b0;
         wbm_dat_o <= '0;
      end
      else
      begin
         wbm_ack_o <= rsp_sel.ack;
         wbm_err_o <= rsp_sel.err;       // error passes straight through
         if (rsp_sel.ack)
            wbm_dat_o <= rsp_sel.rdata;  // otherwise keep last data on the bus
      end
   end

endmodule

// ==== hdl/wbh_local_regs.sv ====
// local configuration registers with write decode, read mux and registered ack
`timescale 1ns/1ns
`include "wbh_params.svh"

module wbh_local_regs
   import wbh_pkg::*;
(
   input  logic       wbm_clk_i,
   input  logic       wbm_rst_n,
   wbh_req_if.target  req,               // local half of the front stage
   output wbh_rsp_t   rsp_o,             // back to front stage
   output wbh_bank_t  bank_o,            // upper address for external port
   output wbh_data_t  cfg_glb_ctrl_o,
   output wbh_data_t  cfg_clk_ctrl1_o,
   output wbh_data_t  cfg_clk_ctrl2_o
);

   wbh_reg_e  reg_idx;    // decoded from adr[3:2]
   logic      req_d;      // req one cycle late
   logic      req_new;    // first cycle of a request
   logic      ack_q;
   wbh_data_t rdata_q;
   wbh_data_t rd_word;    // read mux output
   wbh_data_t glb_q;      // global control
   wbh_bank_t bank_q;     // bank select
   wbh_data_t clk1_q;     // clock control 1
   wbh_data_t clk2_q;     // clock control 2

   assign reg_idx = wbh_reg_e'(req.adr[`WBH_REG_LSB +: `WBH_REG_AW]);
   assign req_new = req.req & ~req_d;   // one hit per held request

   // ------------------------------
   // register write
   // ------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_q  <= '0;
         bank_q <= `WBH_BANK_RST;
         clk1_q <= '0;
         clk2_q <= '0;
      end
      else if (req_new && req.we)
      begin
         case (reg_idx)
            REG_GLB:  glb_q  <= req.wdata;
            REG_BANK: bank_q <= req.wdata[`WBH_BANK_W-1:0];   // low byte only
            REG_CLK1: clk1_q <= req.wdata;
            REG_CLK2: clk2_q <= req.wdata;
         endcase
      end
   end

   // read mux
   always_comb
   begin
      case (reg_idx)
         REG_GLB:  rd_word = glb_q;
         REG_BANK: rd_word = {{(`WBH_DW-`WBH_BANK_W){1'b0}}, bank_q};   // zero-extend
         REG_CLK1: rd_word = clk1_q;
         REG_CLK2: rd_word = clk2_q;
      endcase
   end

   // ------------------------------
   // acknowledge
   // ------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         req_d <= 1'b0;
         ack_q <= 1'b0;
      end
      else
      begin
         req_d <= req.req;
         ack_q <= req_new;   // one cycle after req
      end
   end

   always_ff @(posedge wbm_clk_i)
   begin
      if (req_new && !req.we)
         rdata_q <= rd_word;
   end

   assign rsp_o = '{ack: ack_q, err: 1'b0, rdata: rdata_q};   // never errors

   // configuration outputs
   assign bank_o          = bank_q;
   assign cfg_glb_ctrl_o  = glb_q;
   assign cfg_clk_ctrl1_o = clk1_q;
   assign cfg_clk_ctrl2_o = clk2_q;

endmodule

// ==== hdl/wbh_ext_port.sv ====
// external Wishbone launch with bank address extension and response capture
`timescale 1ns/1ns
`include "wbh_params.svh"

module wbh_ext_port
   import wbh_pkg::*;
(
   input  logic       wbm_clk_i,
   input  logic       wbm_rst_n,
   wbh_req_if.target  req,          // external half of the front stage
   input  wbh_bank_t  bank_i,       // from bank select register
   output wbh_rsp_t   rsp_o,
   output logic       wbs_cyc_o,
   output logic       wbs_stb_o,
   output logic       wbs_we_o,
   output wbh_addr_t  wbs_adr_o,    // {bank, adr[23:0]}
   output wbh_data_t  wbs_dat_o,
   output wbh_sel_t   wbs_sel_o,
   input  wbh_data_t  wbs_dat_i,
   input  logic       wbs_ack_i,
   input  logic       wbs_err_i
);

   logic      done_q;    // answered and waiting for req to fall
   logic      launch;    // start a slave cycle
   logic      slv_end;   // slave answered this cycle
   logic      ack_q;     // slave ack one cycle late
   logic      err_q;     // slave err one cycle late
   wbh_data_t rdata_q;   // data of the last slave ack

   assign launch  = req.req & ~done_q & ~wbs_stb_o;
   assign slv_end = wbs_stb_o & (wbs_ack_i | wbs_err_i);

   // ------------------------------
   // slave cycle control
   // ------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbs_cyc_o <= 1'b0;
         wbs_stb_o <= 1'b0;
         done_q    <= 1'b0;
         ack_q     <= 1'b0;
         err_q     <= 1'b0;
      end
      else
      begin
         if (launch)
         begin
            wbs_cyc_o <= 1'b1;
            wbs_stb_o <= 1'b1;
         end
         else if (slv_end)
         begin
            wbs_cyc_o <= 1'b0;   // end of classic cycle
            wbs_stb_o <= 1'b0;
            done_q    <= 1'b1;
         end
         else if (!req.req)
            done_q <= 1'b0;      // front has taken the response
         ack_q <= wbs_stb_o & wbs_ack_i;   // one-cycle pulse
         err_q <= wbs_stb_o & wbs_err_i;
      end
   end

   // launch payload held through wait states
   always_ff @(posedge wbm_clk_i)
   begin
      if (launch)
      begin
         wbs_adr_o <= {bank_i, req.adr[`WBH_OFFS_W-1:0]};
         wbs_we_o  <= req.we;
         wbs_dat_o <= req.wdata;
         wbs_sel_o <= req.sel;
      end
      if (wbs_stb_o && wbs_ack_i)
         rdata_q <= wbs_dat_i;
   end

   assign rsp_o = '{ack: ack_q, err: err_q, rdata: rdata_q};

endmodule

// ==== hdl/wb_host.sv ====
// Wishbone host bridge top with front stage, local register file and external port
`timescale 1ns/1ns
module wb_host
   import wbh_pkg::*;
(
   input  logic       wbm_clk_i,        // single bridge clock
   input  logic       wbm_rst_n,        // async active low reset
   // master side
   input  logic       wbm_cyc_i,
   input  logic       wbm_stb_i,
   input  logic       wbm_we_i,
   input  wbh_addr_t  wbm_adr_i,
   input  wbh_data_t  wbm_dat_i,
   input  wbh_sel_t   wbm_sel_i,
   output wbh_data_t  wbm_dat_o,
   output logic       wbm_ack_o,
   output logic       wbm_err_o,
   // slave side
   output logic       wbs_cyc_o,
   output logic       wbs_stb_o,
   output logic       wbs_we_o,
   output wbh_addr_t  wbs_adr_o,
   output wbh_data_t  wbs_dat_o,
   output wbh_sel_t   wbs_sel_o,
   input  wbh_data_t  wbs_dat_i,
   input  logic       wbs_ack_i,
   input  logic       wbs_err_i,
   // configuration
   output wbh_data_t  cfg_glb_ctrl_o,
   output wbh_data_t  cfg_clk_ctrl1_o,
   output wbh_data_t  cfg_clk_ctrl2_o
);

   wbh_rsp_t  reg_rsp;   // local register response
   wbh_rsp_t  ext_rsp;   // external port response
   wbh_bank_t bank;      // bank select

   wbh_req_if reg_req ();
   wbh_req_if ext_req ();

   wbh_front u_front (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .wbm_cyc_i (wbm_cyc_i), .wbm_stb_i (wbm_stb_i), .wbm_we_i (wbm_we_i),
      .wbm_adr_i (wbm_adr_i), .wbm_dat_i (wbm_dat_i), .wbm_sel_i (wbm_sel_i),
      .reg_req   (reg_req),   .ext_req   (ext_req),
      .reg_rsp_i (reg_rsp),   .ext_rsp_i (ext_rsp),
      .wbm_dat_o (wbm_dat_o), .wbm_ack_o (wbm_ack_o), .wbm_err_o (wbm_err_o)
   );

   wbh_local_regs u_regs (
      .wbm_clk_i       (wbm_clk_i),       .wbm_rst_n (wbm_rst_n),
      .req             (reg_req),         .rsp_o     (reg_rsp),
      .bank_o          (bank),
      .cfg_glb_ctrl_o  (cfg_glb_ctrl_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),
      .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   wbh_ext_port u_ext (
      .wbm_clk_i (wbm_clk_i), .wbm_rst_n (wbm_rst_n),
      .req       (ext_req),   .bank_i    (bank),      .rsp_o (ext_rsp),
      .wbs_cyc_o (wbs_cyc_o), .wbs_stb_o (wbs_stb_o), .wbs_we_o (wbs_we_o),
      .wbs_adr_o (wbs_adr_o), .wbs_dat_o (wbs_dat_o), .wbs_sel_o (wbs_sel_o),
      .wbs_dat_i (wbs_dat_i), .wbs_ack_i (wbs_ack_i), .wbs_err_i (wbs_err_i)
   );

endmodule

// ==== test/tb_wb_slave.sv ====
// behavioral Wishbone slave memory with random wait states and an error region
`timescale 1ns/1ns

module tb_wb_slave #(
   parameter logic [31:0] SEED = 32'h0000_0001
) (
   input  logic        wbm_clk_i,
   input  logic        cyc_i,
   input  logic        stb_i,
   input  logic        we_i,
   input  logic [31:0] adr_i,
   input  logic [31:0] dat_i,
   input  logic [3:0]  sel_i,
   output logic [31:0] dat_o,
   output logic        ack_o,
   output logic        err_o
);

   logic [31:0] mem [logic [31:0]];   // sparse memory keyed by full address
   logic [31:0] last_adr;             // address of the last answered cycle
   logic [31:0] word;
   logic [31:0] r;
   integer      seed;
   logic        busy;                 // wait states drawn for this cycle
   logic [1:0]  wait_left;

   // contents of a word never written
   function automatic logic [31:0] blank_word(input logic [31:0] a);
      return a ^ 32'h5A0F_C3E1;
   endfunction

   initial
   begin
      seed      = SEED;
      ack_o     = 1'b0;
      err_o     = 1'b0;
      dat_o     = '0;
      busy      = 1'b0;
      wait_left = 2'd0;
      last_adr  = '0;
   end

   // responses change on the falling edge only
   always @(negedge wbm_clk_i)
   begin
      if (ack_o || err_o)
      begin
         ack_o = 1'b0;   // one-cycle response
         err_o = 1'b0;
      end
      else if (cyc_i && stb_i)
      begin
         if (!busy)
         begin
            r         = $random(seed);
            wait_left = r[1:0];   // 0 to 3 wait states
            busy      = 1'b1;
         end
         if (wait_left != 2'd0)
            wait_left = wait_left - 2'd1;
         else
         begin
            busy     = 1'b0;
            last_adr = adr_i;
            word     = mem.exists(adr_i) ? mem[adr_i] : blank_word(adr_i);
            if (adr_i[31:24] == 8'hEE)
               err_o = 1'b1;   // error region leaves memory untouched
            else if (we_i)
            begin
               for (int b = 0; b < 4; b++)
                  if (sel_i[b])
                     word[8*b +: 8] = dat_i[8*b +: 8];
               mem[adr_i] = word;
               ack_o      = 1'b1;
            end
            else
            begin
               dat_o = word;
               ack_o = 1'b1;
            end
         end
      end
   end

endmodule

// ==== test/tb_wb_host.sv ====
// testbench top with clock, reset, directed and random cycles, reference model, checks and watchdog
`timescale 1ns/1ns
`include "wbh_params.svh"

module tb_wb_host
   import wbh_pkg::*;
();

   localparam logic [31:0] SEED    = 32'h2194_8b05;
   localparam int          N_DIR   = 30;    // directed cycles
   localparam int          N_RAND  = 300;   // random cycles
   localparam int          N_OPS   = N_DIR + N_RAND;
   localparam int          RSP_TMO = 40;    // cycles allowed for one response
   localparam wbh_addr_t   LOC     = 32'h0080_0000;   // bit 23 set

   logic      wbm_clk_i;
   logic      wbm_rst_n;
   logic      wbm_cyc_i;
   logic      wbm_stb_i;
   logic      wbm_we_i;
   wbh_addr_t wbm_adr_i;
   wbh_data_t wbm_dat_i;
   wbh_sel_t  wbm_sel_i;
   wbh_data_t wbm_dat_o;
   logic      wbm_ack_o;
   logic      wbm_err_o;
   logic      wbs_cyc_o;
   logic      wbs_stb_o;
   logic      wbs_we_o;
   wbh_addr_t wbs_adr_o;
   wbh_data_t wbs_dat_o;
   wbh_sel_t  wbs_sel_o;
   wbh_data_t wbs_dat_i;
   logic      wbs_ack_i;
   logic      wbs_err_i;
   wbh_data_t cfg_glb_ctrl_o;
   wbh_data_t cfg_clk_ctrl1_o;
   wbh_data_t cfg_clk_ctrl2_o;

   // reference model
   wbh_data_t glb_m;
   wbh_bank_t bank_m;
   wbh_data_t clk1_m;
   wbh_data_t clk2_m;
   wbh_data_t mem_m [wbh_addr_t];   // slave words by full address
   integer    seed;
   logic      rd_pend;              // read waiting for its ack
   wbh_data_t exp_dat;

   wb_host dut (.*);

   tb_wb_slave #(.SEED(SEED)) u_slave (
      .wbm_clk_i (wbm_clk_i), .cyc_i (wbs_cyc_o), .stb_i (wbs_stb_o),
      .we_i      (wbs_we_o),  .adr_i (wbs_adr_o), .dat_i (wbs_dat_o),
      .sel_i     (wbs_sel_o), .dat_o (wbs_dat_i), .ack_o (wbs_ack_i),
      .err_o     (wbs_err_i)
   );

   // ------------------------------
   // reference functions
   // ------------------------------
   function automatic wbh_data_t blank_word(input wbh_addr_t a);
      return a ^ 32'h5A0F_C3E1;   // untouched slave word
   endfunction

   function automatic wbh_addr_t ext_addr(input wbh_addr_t a);
      return {bank_m, a[`WBH_OFFS_W-1:0]};   // bank replaces the top byte
   endfunction

   function automatic wbh_data_t exp_read(input wbh_addr_t a);
      wbh_addr_t full;
      full = ext_addr(a);
      if (a[`WBH_LOCAL_BIT])
      begin
         case (a[3:2])
            2'd0:    return glb_m;
            2'd1:    return {24'h0, bank_m};
            2'd2:    return clk1_m;
            default: return clk2_m;
         endcase
      end
      if (mem_m.exists(full))
         return mem_m[full];
      return blank_word(full);
   endfunction

   task automatic model_write(input wbh_addr_t a, input wbh_data_t d, input wbh_sel_t sel);
      wbh_addr_t full;
      wbh_data_t w;
      full = ext_addr(a);
      if (!a[`WBH_LOCAL_BIT])
      begin
         w = mem_m.exists(full) ? mem_m[full] : blank_word(full);
         for (int b = 0; b < 4; b++)
            if (sel[b])
               w[8*b +: 8] = d[8*b +: 8];   // only enabled bytes change
         mem_m[full] = w;
      end
      else
         case (a[3:2])
            2'd0:    glb_m  = d;
            2'd1:    bank_m = d[7:0];   // low byte only
            2'd2:    clk1_m = d;
            default: clk2_m = d;
         endcase
   endtask

   task automatic check_val(input string name, input wbh_data_t exp, input wbh_data_t act);
      if (exp !== act)
      begin
         $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
         $display("Regression failed");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   // one classic cycle with fields driven on the falling edge
   task automatic bus_cycle(input logic we, input wbh_addr_t a, input wbh_data_t d,
                            input logic exp_err, input wbh_sel_t sel = 4'hF);
      int n;
      n = 0;
      @(negedge wbm_clk_i);
      wbm_cyc_i = 1'b1;
      wbm_stb_i = 1'b1;
      wbm_we_i  = we;
      wbm_adr_i = a;
      wbm_dat_i = d;
      wbm_sel_i = sel;
      exp_dat   = exp_read(a);
      rd_pend   = ~we & ~exp_err;
      @(negedge wbm_clk_i);
      while (!(wbm_ack_o || wbm_err_o) && n < RSP_TMO)
      begin
         @(negedge wbm_clk_i);
         n++;
      end
      if (!(wbm_ack_o || wbm_err_o))
      begin
         $display("bridge gave neither ack nor err for address %h", a);
         $display("Regression failed");
         $fatal(1, "response timeout");
      end
      check_val("wbm_err_o", 32'(exp_err), 32'(wbm_err_o));
      check_val("wbm_ack_o", 32'(!exp_err), 32'(wbm_ack_o));
      check_val("wbs_cyc_o", 32'h0, 32'(wbs_cyc_o));   // slave cycle already closed
      wbm_stb_i = 1'b0;   // drop in the cycle after the response
      wbm_cyc_i = 1'b0;
      if (we && !exp_err)
         model_write(a, d, sel);
   endtask

   // compare read data on each ack
   always @(negedge wbm_clk_i)
   begin
      if (rd_pend && wbm_ack_o)
      begin
         check_val("wbm_dat_o", exp_dat, wbm_dat_o);
         rd_pend = 1'b0;
      end
   end

   // ------------------------------
   // clock, watchdog, stimulus
   // ------------------------------
   initial
   begin
      wbm_clk_i = 1'b0;
      forever #50 wbm_clk_i = ~wbm_clk_i;
   end

   initial
   begin
      repeat (N_OPS * 20) @(posedge wbm_clk_i);
      $display("watchdog expired before the tests completed");
      $display("Regression failed");
      $fatal(1, "watchdog timeout");
   end

   initial
   begin
      wbh_data_t r;
      wbh_data_t d;
      wbh_addr_t la;
      wbh_addr_t xa;
      wbm_rst_n = 1'b0;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      wbm_adr_i = '0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      seed      = SEED;
      glb_m     = '0;
      bank_m    = `WBH_BANK_RST;
      clk1_m    = '0;
      clk2_m    = '0;
      rd_pend   = 1'b0;
      exp_dat   = '0;
      repeat (3) @(negedge wbm_clk_i);
      wbm_rst_n = 1'b1;

      // reset values
      check_val("cfg_glb_ctrl_o", 32'h0, cfg_glb_ctrl_o);
      check_val("cfg_clk_ctrl1_o", 32'h0, cfg_clk_ctrl1_o);
      check_val("cfg_clk_ctrl2_o", 32'h0, cfg_clk_ctrl2_o);
      check_val("wbm_dat_o", 32'h0, wbm_dat_o);
      check_val("wbm_ack_o", 32'h0, 32'(wbm_ack_o));
      check_val("wbm_err_o", 32'h0, 32'(wbm_err_o));
      check_val("wbs_cyc_o", 32'h0, 32'(wbs_cyc_o));
      check_val("wbs_stb_o", 32'h0, 32'(wbs_stb_o));
      for (int i = 0; i < 4; i++)
         bus_cycle(1'b0, LOC + wbh_addr_t'(4 * i), '0, 1'b0);

      // local write and readback
      bus_cycle(1'b1, LOC + 32'd0, 32'hA5C3_0F01, 1'b0);
      bus_cycle(1'b1, LOC + 32'd4, 32'h1234_5633, 1'b0);   // bank gets 8'h33
      bus_cycle(1'b1, LOC + 32'd8, 32'hDEAD_0102, 1'b0);
      bus_cycle(1'b1, LOC + 32'd12, 32'h0BAD_F00D, 1'b0);
      for (int i = 0; i < 4; i++)
         bus_cycle(1'b0, LOC + wbh_addr_t'(4 * i), '0, 1'b0);
      check_val("cfg_glb_ctrl_o", 32'hA5C3_0F01, cfg_glb_ctrl_o);
      check_val("cfg_clk_ctrl1_o", 32'hDEAD_0102, cfg_clk_ctrl1_o);
      check_val("cfg_clk_ctrl2_o", 32'h0BAD_F00D, cfg_clk_ctrl2_o);

      // external write and read in bank 8'h20
      bus_cycle(1'b1, LOC + 32'd4, 32'h0000_0020, 1'b0);
      bus_cycle(1'b1, 32'h7F00_1230, 32'hCAFE_0001, 1'b0);
      check_val("slave last_adr", 32'h2000_1230, u_slave.last_adr);
      bus_cycle(1'b0, 32'h7F00_1230, '0, 1'b0);
      check_val("slave last_adr", 32'h2000_1230, u_slave.last_adr);

      // same low address in bank 8'h21
      bus_cycle(1'b1, LOC + 32'd4, 32'h0000_0021, 1'b0);
      bus_cycle(1'b1, 32'h0000_1230, 32'hBEEF_0002, 1'b0);
      bus_cycle(1'b0, 32'h0000_1230, '0, 1'b0);
      check_val("slave last_adr", 32'h2100_1230, u_slave.last_adr);
      bus_cycle(1'b1, LOC + 32'd4, 32'h0000_0020, 1'b0);
      bus_cycle(1'b0, 32'h0000_1230, '0, 1'b0);   // first word still there

      // error region then recovery
      bus_cycle(1'b1, LOC + 32'd4, 32'h0000_00EE, 1'b0);
      bus_cycle(1'b0, 32'h0000_0100, '0, 1'b1);
      bus_cycle(1'b1, 32'h0000_0100, 32'h1111_2222, 1'b1);
      bus_cycle(1'b1, LOC + 32'd4, 32'h0000_0020, 1'b0);
      bus_cycle(1'b0, 32'h0000_1230, '0, 1'b0);

      // random mix over 16 words per bank
      for (int k = 0; k < N_RAND; k++)
      begin
         r  = $random(seed);
         d  = $random(seed);
         la = {8'h00, 1'b1, 19'h0, r[13:12], 2'b00};
         xa = {r[31:24], 1'b0, 17'h0, r[5:2], 2'b00};   // top byte dropped by bridge
         if (r[13:12] == 2'd1)
            d = {d[31:8], 7'h10, d[0]};   // bank stays 8'h20 or 8'h21
         case (r[10:8])
            3'd0, 3'd1: bus_cycle(1'b1, la, d, 1'b0);
            3'd2, 3'd3: bus_cycle(1'b0, la, d, 1'b0);
            3'd4, 3'd5: bus_cycle(1'b1, xa, d, 1'b0, r[19:16]);   // random byte enables
            default:    bus_cycle(1'b0, xa, d, 1'b0);
         endcase
      end

      $display("Regression passed");
      $finish;
   end

endmodule

// ==== tb.f ====
+incdir+include
hdl/wbh_pkg.sv
hdl/wbh_req_if.sv
hdl/wbh_front.sv
hdl/wbh_local_regs.sv
hdl/wbh_ext_port.sv
hdl/wb_host.sv
test/tb_wb_slave.sv
test/tb_wb_host.sv

// ==== Makefile ====
TB_TOP := tb_wb_host

.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+include --top-module wb_host \
		hdl/wbh_pkg.sv hdl/wbh_req_if.sv hdl/wbh_front.sv \
		hdl/wbh_local_regs.sv hdl/wbh_ext_port.sv hdl/wb_host.sv

sim:
	verilator --binary --timing -f tb.f --top-module $(TB_TOP) -o $(TB_TOP)
	@out="$$(./obj_dir/$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf obj_dir
